/* src/matinv_pkg.sv */
`default_nettype none

package matinv_pkg;

	////////////////////
	// Matrix geometry
	localparam int MAT_N      = 5;
	localparam int AUG_COLS   = 2 * MAT_N;
	localparam int ELEM_COUNT = MAT_N * MAT_N;
	localparam int OUT_COUNT  = ELEM_COUNT + MAT_N;

	////////////////////
	// Word and index widths
	localparam int WORD_W = 32;
	localparam int ROW_W  = $clog2(MAT_N);
	localparam int COL_W  = $clog2(AUG_COLS);
	localparam int ELEM_W = $clog2(ELEM_COUNT);

	////////////////////
	// Elimination FSM encoding
	localparam int STATE_W = 2;
	localparam logic [STATE_W-1:0] ST_IDLE   = 2'd0;
	localparam logic [STATE_W-1:0] ST_ELIM   = 2'd1;
	localparam logic [STATE_W-1:0] ST_CHECK  = 2'd2;
	localparam logic [STATE_W-1:0] ST_STREAM = 2'd3;

endpackage

`default_nettype wire

/* src/matrix_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module matrix_loader (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           in_valid,
	input  wire  [matinv_pkg::WORD_W-1:0] in_data,
	input  wire                           busy,
	output logic                          load_we,
	output logic [matinv_pkg::ROW_W-1:0]  load_row,
	output logic [matinv_pkg::COL_W-1:0]  load_col,
	output logic [matinv_pkg::WORD_W-1:0] load_data,
	output logic                          start
);
	import matinv_pkg::*;

	logic [ROW_W-1:0]  row_cnt;
	logic [COL_W-1:0]  col_cnt;
	logic [ELEM_W-1:0] elem_cnt;

	// Busy is not up yet while start is high, so block that cycle too
	assign load_we   = in_valid && !busy && !start;
	assign load_row  = row_cnt;
	assign load_col  = col_cnt;
	assign load_data = in_data;

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			row_cnt  <= '0;
			col_cnt  <= '0;
			elem_cnt <= '0;
			start    <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			if (load_we)
			begin
				if (elem_cnt == ELEM_W'(ELEM_COUNT - 1))
				begin
					// Last element, hand over to the engine
					row_cnt  <= '0;
					col_cnt  <= '0;
					elem_cnt <= '0;
					start    <= 1'b1;
				end
				else
				begin
					elem_cnt <= elem_cnt + 1'b1;
					if (col_cnt == COL_W'(MAT_N - 1))
					begin
						col_cnt <= '0;
						row_cnt <= row_cnt + 1'b1;
					end
					else
					begin
						col_cnt <= col_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/augmented_store.sv */
`timescale 1ns/10ps
`default_nettype none

module augmented_store (
	input  wire                           clk,
	input  wire                           load_we,
	input  wire  [matinv_pkg::ROW_W-1:0]  load_row,
	input  wire  [matinv_pkg::COL_W-1:0]  load_col,
	input  wire  [matinv_pkg::WORD_W-1:0] load_data,
	input  wire  [matinv_pkg::ROW_W-1:0]  pivot_row,
	input  wire  [matinv_pkg::ROW_W-1:0]  target_row,
	input  wire                           row_we,
	input  wire  [matinv_pkg::WORD_W-1:0] new_row [matinv_pkg::AUG_COLS],
	output logic [matinv_pkg::WORD_W-1:0] pivot_data [matinv_pkg::AUG_COLS],
	output logic [matinv_pkg::WORD_W-1:0] target_data [matinv_pkg::AUG_COLS]
);
	import matinv_pkg::*;

	// Columns 0..4 hold the matrix, 5..9 the identity side
	logic [WORD_W-1:0] mem [MAT_N][AUG_COLS];

	logic [COL_W-1:0]  ident_col;
	logic [WORD_W-1:0] ident_word;

	assign ident_col  = load_col + COL_W'(MAT_N);
	assign ident_word = (COL_W'(load_row) == load_col) ? WORD_W'(1) : '0;

	////////////////////
	// Write side
	always_ff @(posedge clk)
	begin
		if (row_we)
		begin
			for (int c = 0; c < AUG_COLS; c++)
			begin
				mem[target_row][c] <= new_row[c];
			end
		end
		else if (load_we)
		begin
			// Identity half is rebuilt alongside every matrix word
			mem[load_row][load_col]  <= load_data;
			mem[load_row][ident_col] <= ident_word;
		end
	end

	////////////////////
	// Read side, two row ports
	always_comb
	begin
		for (int c = 0; c < AUG_COLS; c++)
		begin
			pivot_data[c] = mem[pivot_row][c];
		end
	end

	always_comb
	begin
		for (int c = 0; c < AUG_COLS; c++)
		begin
			target_data[c] = mem[target_row][c];
		end
	end

endmodule

`default_nettype wire

/* src/gauss_jordan_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module gauss_jordan_engine (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           start,
	input  wire  [matinv_pkg::WORD_W-1:0] pivot_data [matinv_pkg::AUG_COLS],
	input  wire  [matinv_pkg::WORD_W-1:0] target_data [matinv_pkg::AUG_COLS],
	output logic [matinv_pkg::ROW_W-1:0]  pivot_row,
	output logic [matinv_pkg::ROW_W-1:0]  target_row,
	output logic                          row_we,
	output logic [matinv_pkg::WORD_W-1:0] new_row [matinv_pkg::AUG_COLS],
	output logic                          busy,
	output logic                          out_valid,
	output logic [matinv_pkg::WORD_W-1:0] out_data,
	output logic                          done,
	output logic                          singular
);
	import matinv_pkg::*;

	logic [STATE_W-1:0] state;
	logic [ROW_W-1:0]   k;
	logic [ROW_W-1:0]   i;
	logic [COL_W-1:0]   col;
	logic [MAT_N-1:0]   diag_zero;
	logic [WORD_W-1:0]  x;
	logic [WORD_W-1:0]  y;
	logic [ROW_W-1:0]   next_i;
	logic               last_row;

	// k addresses the pivot row, i the row being updated or streamed
	assign pivot_row  = k;
	assign target_row = i;
	assign row_we     = (state == ST_ELIM);
	assign busy       = (state != ST_IDLE);
	assign out_valid  = (state == ST_STREAM);
	assign out_data   = target_data[col];

	////////////////////
	// Fraction-free row update
	assign x = pivot_data[k];
	assign y = target_data[k];

	always_comb
	begin
		for (int c = 0; c < AUG_COLS; c++)
		begin
			new_row[c] = x * target_data[c] - y * pivot_data[c];
		end
	end

	// Step to the next row, hopping over the pivot
	always_comb
	begin
		next_i = i + 1'b1;
		if (next_i == k)
		begin
			next_i = i + 2'd2;
		end
	end

	assign last_row = (next_i > ROW_W'(MAT_N - 1));

	// Each row's last write leaves its final diagonal
	always_ff @(posedge clk)
	begin
		if (row_we)
		begin
			diag_zero[target_row] <= (new_row[target_row] == '0);
		end
	end

	////////////////////
	// Sequencer
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state    <= ST_IDLE;
			k        <= '0;
			i        <= '0;
			col      <= '0;
			done     <= 1'b0;
			singular <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state    <= ST_ELIM;
						k        <= '0;
						i        <= ROW_W'(1);
						singular <= 1'b0;
					end
				end
				ST_ELIM:
				begin
					if (!last_row)
					begin
						i <= next_i;
					end
					else if (k == ROW_W'(MAT_N - 1))
					begin
						state <= ST_CHECK;
					end
					else
					begin
						k <= k + 1'b1;
						i <= '0;
					end
				end
				ST_CHECK:
				begin
					singular <= |diag_zero;
					state    <= ST_STREAM;
					i        <= '0;
					col      <= COL_W'(MAT_N);
				end
				ST_STREAM:
				begin
					// Right half first, then col tracks i along the diagonal
					if (col >= COL_W'(MAT_N))
					begin
						if (col == COL_W'(AUG_COLS - 1))
						begin
							if (i == ROW_W'(MAT_N - 1))
							begin
								i   <= '0;
								col <= '0;
							end
							else
							begin
								i   <= i + 1'b1;
								col <= COL_W'(MAT_N);
							end
						end
						else
						begin
							col <= col + 1'b1;
						end
					end
					else if (i == ROW_W'(MAT_N - 1))
					begin
						state <= ST_IDLE;
						done  <= 1'b1;
					end
					else
					begin
						i   <= i + 1'b1;
						col <= col + 1'b1;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/matrix_inverter.sv */
`timescale 1ns/10ps
`default_nettype none

module matrix_inverter (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           in_valid,
	input  wire  [matinv_pkg::WORD_W-1:0] in_data,
	output logic                          busy,
	output logic                          out_valid,
	output logic [matinv_pkg::WORD_W-1:0] out_data,
	output logic                          done,
	output logic                          singular
);
	import matinv_pkg::*;

	wire              load_we;
	wire [ROW_W-1:0]  load_row;
	wire [COL_W-1:0]  load_col;
	wire [WORD_W-1:0] load_data;
	wire              start;
	wire [ROW_W-1:0]  pivot_row;
	wire [ROW_W-1:0]  target_row;
	wire              row_we;
	wire [WORD_W-1:0] new_row [AUG_COLS];
	wire [WORD_W-1:0] pivot_data [AUG_COLS];
	wire [WORD_W-1:0] target_data [AUG_COLS];

	matrix_loader i_loader (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.busy      (busy),
		.load_we   (load_we),
		.load_row  (load_row),
		.load_col  (load_col),
		.load_data (load_data),
		.start     (start)
	);

	augmented_store i_store (
		.clk         (clk),
		.load_we     (load_we),
		.load_row    (load_row),
		.load_col    (load_col),
		.load_data   (load_data),
		.pivot_row   (pivot_row),
		.target_row  (target_row),
		.row_we      (row_we),
		.new_row     (new_row),
		.pivot_data  (pivot_data),
		.target_data (target_data)
	);

	gauss_jordan_engine i_engine (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.pivot_data  (pivot_data),
		.target_data (target_data),
		.pivot_row   (pivot_row),
		.target_row  (target_row),
		.row_we      (row_we),
		.new_row     (new_row),
		.busy        (busy),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.done        (done),
		.singular    (singular)
	);

endmodule

`default_nettype wire

/* include/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Software model of the engine, same row order and 32-bit wrap
function automatic void ref_model(
	input  logic [matinv_pkg::WORD_W-1:0] mat [matinv_pkg::ELEM_COUNT],
	output logic [matinv_pkg::WORD_W-1:0] exp_words [matinv_pkg::OUT_COUNT],
	output logic                          exp_singular
);
	logic [matinv_pkg::WORD_W-1:0] aug [matinv_pkg::MAT_N][matinv_pkg::AUG_COLS];
	logic [matinv_pkg::WORD_W-1:0] x;
	logic [matinv_pkg::WORD_W-1:0] y;
	int n;

	for (int r = 0; r < matinv_pkg::MAT_N; r++)
	begin
		for (int c = 0; c < matinv_pkg::MAT_N; c++)
		begin
			aug[r][c] = mat[r * matinv_pkg::MAT_N + c];
			aug[r][c + matinv_pkg::MAT_N] = (r == c) ? 1 : 0;
		end
	end

	for (int k = 0; k < matinv_pkg::MAT_N; k++)
	begin
		for (int i = 0; i < matinv_pkg::MAT_N; i++)
		begin
			if (i != k)
			begin
				// y is taken before the row changes
				x = aug[k][k];
				y = aug[i][k];
				for (int c = 0; c < matinv_pkg::AUG_COLS; c++)
				begin
					aug[i][c] = x * aug[i][c] - y * aug[k][c];
				end
			end
		end
	end

	n = 0;
	exp_singular = 1'b0;
	for (int r = 0; r < matinv_pkg::MAT_N; r++)
	begin
		for (int c = matinv_pkg::MAT_N; c < matinv_pkg::AUG_COLS; c++)
		begin
			exp_words[n] = aug[r][c];
			n++;
		end
	end
	for (int r = 0; r < matinv_pkg::MAT_N; r++)
	begin
		exp_words[n] = aug[r][r];
		exp_singular = exp_singular | (aug[r][r] == '0);
		n++;
	end
endfunction

`endif

/* tests/tb_matrix_inverter.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_matrix_inverter;
	import matinv_pkg::*;

	localparam int DONE_LIMIT = 200;

	logic              clk;
	logic              reset;
	logic              in_valid;
	logic [WORD_W-1:0] in_data;
	wire               busy;
	wire               out_valid;
	wire  [WORD_W-1:0] out_data;
	wire               done;
	wire               singular;

	logic [WORD_W-1:0] mat [ELEM_COUNT];
	logic [WORD_W-1:0] exp_words [OUT_COUNT];
	logic [WORD_W-1:0] got_words [OUT_COUNT];
	logic              exp_singular;
	string             cur_test;
	int                out_idx;
	int                done_cnt;
	int                stream_runs;
	int                errors;
	int                checks;
	int                tests;
	bit                prev_valid;
	bit                timed_out;
	integer            seed;

	`include "tb_ref_model.svh"

	matrix_inverter i_dut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.busy      (busy),
		.out_valid (out_valid),
		.out_data  (out_data),
		.done      (done),
		.singular  (singular)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#20 clk = ~clk;
		end
	end

	task automatic check_equal(input string name, input logic [WORD_W-1:0] expv,
		input logic [WORD_W-1:0] actv);
		checks++;
		if (actv !== expv)
		begin
			$display("ERR %s expected %h actual %h", name, expv, actv);
			errors++;
		end
	endtask

	////////////////////
	// Output collector
	always @(negedge clk)
	begin
		if (out_valid)
		begin
			if (!prev_valid)
			begin
				stream_runs++;
			end
			if (out_idx == 0)
			begin
				check_equal({cur_test, " singular"}, exp_singular, singular);
			end
			if (out_idx < OUT_COUNT)
			begin
				got_words[out_idx] = out_data;
				check_equal($sformatf("%s word %0d", cur_test, out_idx),
					exp_words[out_idx], out_data);
			end
			else
			begin
				$display("%s: out_valid stayed high after the last expected word", cur_test);
				errors++;
			end
			out_idx++;
		end
		if (done)
		begin
			done_cnt++;
		end
		prev_valid = out_valid;
	end

	////////////////////
	// Stimulus helpers
	task automatic random_matrix();
		integer v;
		for (int n = 0; n < ELEM_COUNT; n++)
		begin
			// Entries from -8 to 7
			v = ($random(seed) & 15) - 8;
			mat[n] = v;
		end
	endtask

	// Loads mat, then waits for done; garbage keeps strobing while busy
	task automatic run_matrix(input string name, input bit garbage);
		int cycles;
		bit seen;
		cur_test = name;
		out_idx = 0;
		done_cnt = 0;
		stream_runs = 0;
		for (int n = 0; n < ELEM_COUNT; n++)
		begin
			@(negedge clk);
			in_valid = 1'b1;
			in_data = mat[n];
		end
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < DONE_LIMIT)
		begin
			@(negedge clk);
			if (done)
			begin
				seen = 1'b1;
				in_valid = 1'b0;
			end
			else
			begin
				in_valid = garbage;
				if (garbage)
				begin
					in_data = $random(seed);
				end
				cycles++;
			end
		end
		if (!seen)
		begin
			$display("%s: no done pulse within %0d cycles", name, DONE_LIMIT);
			in_valid = 1'b0;
			timed_out = 1'b1;
			return;
		end
		@(negedge clk);
		check_equal({name, " word count"}, OUT_COUNT, out_idx);
		check_equal({name, " done pulses"}, 1, done_cnt);
		check_equal({name, " valid bursts"}, 1, stream_runs);
		check_equal({name, " singular held"}, exp_singular, singular);
		check_equal({name, " busy after done"}, 0, busy);
	endtask

	task automatic report_test(input string name, input int err_start);
		tests++;
		if (errors == err_start)
		begin
			$display("%s: ok", name);
		end
		else
		begin
			$display("%s: %0d errors", name, errors - err_start);
		end
	endtask

	task automatic random_test(input string name, input bit garbage);
		int err_start;
		err_start = errors;
		random_matrix();
		ref_model(mat, exp_words, exp_singular);
		run_matrix(name, garbage);
		if (!timed_out)
		begin
			report_test(name, err_start);
		end
	endtask

	////////////////////
	// Test sequence
	task automatic run_all();
		int err_start;
		int r;
		int c;

		// Identity in, identity out with unit diagonals
		err_start = errors;
		for (int n = 0; n < ELEM_COUNT; n++)
		begin
			mat[n] = (n / MAT_N == n % MAT_N) ? 1 : 0;
		end
		for (int n = 0; n < ELEM_COUNT; n++)
		begin
			exp_words[n] = (n / MAT_N == n % MAT_N) ? 1 : 0;
		end
		for (int n = ELEM_COUNT; n < OUT_COUNT; n++)
		begin
			exp_words[n] = 1;
		end
		exp_singular = 1'b0;
		run_matrix("identity", 1'b0);
		if (timed_out)
		begin
			return;
		end
		report_test("identity", err_start);

		// Diagonal 2..6
		err_start = errors;
		for (int n = 0; n < ELEM_COUNT; n++)
		begin
			r = n / MAT_N;
			c = n % MAT_N;
			mat[n] = (r == c) ? r + 2 : 0;
		end
		ref_model(mat, exp_words, exp_singular);
		run_matrix("diagonal", 1'b0);
		if (timed_out)
		begin
			return;
		end
		for (int n = 0; n < ELEM_COUNT; n++)
		begin
			r = n / MAT_N;
			c = n % MAT_N;
			if (r != c)
			begin
				check_equal("diagonal off-diag inverse", 0, got_words[n]);
			end
			else
			begin
				// right / diag must equal 1 / d
				check_equal("diagonal inverse", got_words[ELEM_COUNT + r],
					(r + 2) * got_words[n]);
			end
		end
		report_test("diagonal", err_start);

		for (int t = 0; t < 4; t++)
		begin
			random_test($sformatf("random_%0d", t), 1'b0);
			if (timed_out)
			begin
				return;
			end
		end

		// Rows 1 and 3 equal
		err_start = errors;
		random_matrix();
		for (int j = 0; j < MAT_N; j++)
		begin
			mat[3 * MAT_N + j] = mat[MAT_N + j];
		end
		ref_model(mat, exp_words, exp_singular);
		run_matrix("equal_rows", 1'b0);
		if (timed_out)
		begin
			return;
		end
		check_equal("equal_rows singular set", 1, singular);
		report_test("equal_rows", err_start);

		random_test("busy_ignore", 1'b1);
		if (timed_out)
		begin
			return;
		end
		random_test("reload", 1'b0);
		if (timed_out)
		begin
			return;
		end
		random_test("back_to_back_0", 1'b0);
		if (timed_out)
		begin
			return;
		end
		random_test("back_to_back_1", 1'b0);
	endtask

	initial
	begin
		reset = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		seed = 8;
		errors = 0;
		checks = 0;
		tests = 0;
		out_idx = 0;
		done_cnt = 0;
		stream_runs = 0;
		prev_valid = 1'b0;
		timed_out = 1'b0;
		cur_test = "reset";
		repeat (3) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		run_all();
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0 && !timed_out)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
src/matinv_pkg.sv
src/matrix_loader.sv
src/augmented_store.sv
src/gauss_jordan_engine.sv
src/matrix_inverter.sv
tests/tb_matrix_inverter.sv
